//--- rtl/lock_params.svh
`ifndef LOCK_PARAMS_SVH
`define LOCK_PARAMS_SVH

// stored combination, three bcd nibbles
`define LOCK_CODE 12'h246

// wrong attempts before the lock blocks
`define MAX_TRIES 3'd6

// display words
`define DISP_BLANK   12'hfff    // dark display
`define DISP_OPEN    12'hbcc    // shows "ASS"
`define DISP_BLOCKED 12'h000    // blocked indication

// buzzer timing in clock cycles
// kept short for simulation; hardware wants about 1 s and a kHz tone
`define BEEP_CYCLES 64
`define TONE_HALF   4

`endif

//--- rtl/lock_pkg.sv
package lock_pkg;

    typedef logic [15:0] keys_t;    // one-hot keypad word
    typedef logic [3:0]  digit_t;   // bcd digit
    typedef logic [11:0] code_t;    // three digits, newest in low nibble
    typedef logic [2:0]  tries_t;   // wrong attempt count

    typedef enum logic [1:0] {
        KEY_DIGIT,
        KEY_ENTER,
        KEY_CLEAR,
        KEY_RESET
    } key_kind_t;

    // decoder to entry link
    typedef struct packed {
        logic      valid;
        key_kind_t kind;
        digit_t    digit;   // only meaningful for KEY_DIGIT
    } key_event_t;

    // entry to checker link
    typedef struct packed {
        logic  submit;
        logic  clear;
        logic  reset_tries;
        code_t code;        // buffer at submit time
    } entry_req_t;

    typedef enum logic [1:0] {
        ST_LOCKED,
        ST_OPEN,
        ST_BLOCKED
    } lock_state_t;

endpackage

//--- rtl/key_decoder.sv
`timescale 1ns/1ps

module key_decoder import lock_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  keys_t      keys,
    output key_event_t key_event
);

    keys_t     prev_keys;   // word seen on the last edge
    logic      hit;         // keys is a single mapped key
    key_kind_t kind;
    digit_t    digit;

    // keypad map, matches the board wiring
    always_comb begin
        hit   = 1'b1;
        kind  = KEY_DIGIT;
        digit = 4'd0;
        case (keys)
            16'h0008: digit = 4'd0;
            16'h0080: digit = 4'd1;
            16'h0040: digit = 4'd2;
            16'h0020: digit = 4'd3;
            16'h0800: digit = 4'd4;
            16'h0400: digit = 4'd5;
            16'h0200: digit = 4'd6;
            16'h8000: digit = 4'd7;
            16'h4000: digit = 4'd8;
            16'h2000: digit = 4'd9;
            16'h0001: kind  = KEY_ENTER;
            16'h1000: kind  = KEY_CLEAR;
            16'h0100: kind  = KEY_RESET;
            default:  hit   = 1'b0;     // zero, multi-hot or unused bit
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_keys <= '0;
            key_event <= '0;
        end else begin
            prev_keys       <= keys;
            key_event.valid <= hit && (keys != prev_keys);  // held key gives one event
            key_event.kind  <= kind;
            key_event.digit <= digit;
        end
    end

    // back-to-back events need a new key word on each of the two edges
    assert property (@(posedge clk) disable iff (rst)
        key_event.valid && $past(key_event.valid) |->
            ($past(keys, 1) != $past(keys, 2)) && ($past(keys, 2) != $past(keys, 3)))
        else $error("key event repeated without a key change");

endmodule

//--- rtl/code_entry.sv
`timescale 1ns/1ps

`include "lock_params.svh"

module code_entry import lock_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  key_event_t key_event,
    output entry_req_t req,
    output code_t      entry_code
);

    logic [2:0] digit_cnt;  // digits held in the buffer

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_code <= `DISP_BLANK;
            digit_cnt  <= '0;
            req        <= '0;
        end else begin
            req.submit      <= 1'b0;
            req.clear       <= 1'b0;
            req.reset_tries <= 1'b0;
            req.code        <= entry_code;
            if (key_event.valid) begin
                case (key_event.kind)
                    KEY_DIGIT: begin
                        if (digit_cnt < 3'd3) begin
                            entry_code <= {entry_code[7:0], key_event.digit};
                            digit_cnt  <= digit_cnt + 3'd1;
                        end     // fourth digit dropped
                    end
                    KEY_ENTER: begin
                        if (digit_cnt == 3'd3) begin
                            req.submit <= 1'b1;
                            entry_code <= `DISP_BLANK;
                            digit_cnt  <= '0;
                        end
                    end
                    KEY_CLEAR: begin
                        req.clear  <= 1'b1;
                        entry_code <= `DISP_BLANK;
                        digit_cnt  <= '0;
                    end
                    KEY_RESET: begin
                        req.clear       <= 1'b1;    // reset also empties the entry
                        req.reset_tries <= 1'b1;
                        entry_code      <= `DISP_BLANK;
                        digit_cnt       <= '0;
                    end
                endcase
            end
        end
    end

    // buffer holds at most three digits
    assert property (@(posedge clk) disable iff (rst)
        digit_cnt <= 3'd3)
        else $error("digit count above three");

    // submitted code always has three real digits
    assert property (@(posedge clk) disable iff (rst)
        req.submit |-> (req.code[11:8] <= 4'd9) && (req.code[7:4] <= 4'd9)
                       && (req.code[3:0] <= 4'd9))
        else $error("submit with incomplete code");

endmodule

//--- rtl/code_checker.sv
`timescale 1ns/1ps

`include "lock_params.svh"

module code_checker import lock_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  entry_req_t req,
    input  code_t      entry_code,
    output code_t      display,
    output tries_t     tries,
    output logic       unlocked,
    output logic       beep
);

    lock_state_t state;
    lock_state_t state_next;
    tries_t      tries_next;
    logic        beep_next;

    always_comb begin
        state_next = state;
        tries_next = tries;
        beep_next  = 1'b0;
        case (state)
            ST_LOCKED: begin
                if (req.submit) begin
                    if (req.code == `LOCK_CODE) begin
                        state_next = ST_OPEN;
                    end else begin
                        tries_next = tries + 3'd1;
                        beep_next  = 1'b1;      // every wrong try beeps
                        if (tries_next == `MAX_TRIES) begin
                            state_next = ST_BLOCKED;
                        end
                    end
                end
            end
            ST_OPEN: begin
                if (req.clear) begin
                    state_next = ST_LOCKED;
                end
            end
            ST_BLOCKED: begin
                if (req.reset_tries) begin
                    state_next = ST_LOCKED;
                end
            end
            default: state_next = ST_LOCKED;
        endcase
        if (req.reset_tries) begin
            tries_next = '0;    // any state
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_LOCKED;
            tries   <= '0;
            beep    <= 1'b0;
            display <= `DISP_BLANK;
        end else begin
            state <= state_next;
            tries <= tries_next;
            beep  <= beep_next;
            case (state_next)
                ST_OPEN:    display <= `DISP_OPEN;
                ST_BLOCKED: display <= `DISP_BLOCKED;
                default:    display <= entry_code;  // live entry while locked
            endcase
        end
    end

    assign unlocked = (state == ST_OPEN);

    assert property (@(posedge clk) disable iff (rst)
        tries <= `MAX_TRIES)
        else $error("tries above limit");

    // blocked only after the full count of wrong tries
    assert property (@(posedge clk) disable iff (rst)
        state == ST_BLOCKED |-> tries == `MAX_TRIES)
        else $error("blocked with tries %0d", tries);

endmodule

//--- rtl/buzzer_driver.sv
`timescale 1ns/1ps

module buzzer_driver #(
    parameter int beep_len    = 64,
    parameter int half_period = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic beep,
    output logic buzzer
);

    localparam int LEN_W  = $clog2(beep_len);
    localparam int TONE_W = (half_period > 1) ? $clog2(half_period) : 1;

    logic              active;
    logic [LEN_W-1:0]  len_cnt;     // cycles left in the beep
    logic [TONE_W-1:0] tone_cnt;    // cycles left in this half period

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            buzzer   <= 1'b0;
            len_cnt  <= '0;
            tone_cnt <= '0;
        end else if (beep) begin
            active   <= 1'b1;       // start or restart
            buzzer   <= 1'b1;
            len_cnt  <= LEN_W'(beep_len - 1);
            tone_cnt <= TONE_W'(half_period - 1);
        end else if (active) begin
            if (len_cnt == '0) begin
                active <= 1'b0;
                buzzer <= 1'b0;     // beep over
            end else begin
                len_cnt <= len_cnt - 1'b1;
                if (tone_cnt == '0) begin
                    buzzer   <= ~buzzer;
                    tone_cnt <= TONE_W'(half_period - 1);
                end else begin
                    tone_cnt <= tone_cnt - 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        !active |-> !buzzer)
        else $error("buzzer high while idle");

endmodule

//--- rtl/keypad_lock.sv
`timescale 1ns/1ps

`include "lock_params.svh"

module keypad_lock import lock_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  keys_t  keys,
    output code_t  display,
    output tries_t tries,
    output logic   unlocked,
    output logic   buzzer
);

    key_event_t key_event;
    entry_req_t req;
    code_t      entry_code;
    logic       beep;

    key_decoder u_key_decoder (
        .clk       (clk),
        .rst       (rst),
        .keys      (keys),
        .key_event (key_event)
    );

    code_entry u_code_entry (
        .clk        (clk),
        .rst        (rst),
        .key_event  (key_event),
        .req        (req),
        .entry_code (entry_code)
    );

    code_checker u_code_checker (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .entry_code (entry_code),
        .display    (display),
        .tries      (tries),
        .unlocked   (unlocked),
        .beep       (beep)
    );

    buzzer_driver #(
        .beep_len    (`BEEP_CYCLES),
        .half_period (`TONE_HALF)
    ) u_buzzer_driver (
        .clk    (clk),
        .rst    (rst),
        .beep   (beep),
        .buzzer (buzzer)
    );

endmodule

//--- testbench/keypad_lock_tb.sv
`timescale 1ns/1ps

`include "lock_params.svh"

module keypad_lock_tb import lock_pkg::*; ();

    typedef struct packed {
        lock_state_t st;
        code_t       buffer;
        logic [2:0]  count;
        tries_t      tries;
        code_t       display;   // expected outputs from here on
        logic        unlocked;
        logic        beep;
    } model_t;

    localparam int    max_cycles = 4000;
    localparam int    digit_bit [10] = '{3, 7, 6, 5, 11, 10, 9, 15, 14, 13};
    localparam keys_t enter_key = 16'h0001;
    localparam keys_t clear_key = 16'h1000;
    localparam keys_t reset_key = 16'h0100;

    logic   clk;
    logic   rst;
    keys_t  keys;
    code_t  display;
    tries_t tries;
    logic   unlocked;
    logic   buzzer;

    model_t model;
    event   pressed;
    int     cycle_cnt = 0;
    int     buzz_high = 0;  // running count of cycles with buzzer high

    keypad_lock DUT (
        .clk      (clk),
        .rst      (rst),
        .keys     (keys),
        .display  (display),
        .tries    (tries),
        .unlocked (unlocked),
        .buzzer   (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // -1 for anything that is not a single mapped key
    function automatic int key_code(input keys_t word);
        int idx;
        int code;
        idx  = -1;
        code = -1;
        if ($countones(word) == 1) begin
            for (int b = 0; b < 16; b++) begin
                if (word[b]) idx = b;
            end
            for (int d = 0; d < 10; d++) begin
                if (digit_bit[d] == idx) code = d;
            end
            if (idx == 0) code = 10;    // enter
            if (idx == 12) code = 11;   // clear
            if (idx == 8) code = 12;    // reset
        end
        return code;
    endfunction

    function automatic keys_t digit_key(input digit_t d);
        return keys_t'(16'h1 << digit_bit[d]);
    endfunction

    function automatic code_t random_wrong_code();
        code_t c;
        do begin
            c = {digit_t'($urandom % 10), digit_t'($urandom % 10), digit_t'($urandom % 10)};
        end while (c == `LOCK_CODE);
        return c;
    endfunction

    // applies one key word to the lock model
    function automatic model_t lock_model(input model_t m, input keys_t word);
        model_t n;
        int     k;
        n      = m;
        n.beep = 1'b0;
        k      = key_code(word);
        if (k >= 0 && k <= 9) begin
            if (n.count < 3) begin
                n.buffer = {n.buffer[7:0], digit_t'(k)};
                n.count  = n.count + 3'd1;
            end
        end else if (k == 10) begin
            if (n.count == 3) begin
                if (n.st == ST_LOCKED) begin
                    if (n.buffer == `LOCK_CODE) begin
                        n.st = ST_OPEN;
                    end else begin
                        n.tries = n.tries + 3'd1;
                        n.beep  = 1'b1;
                        if (n.tries == `MAX_TRIES) n.st = ST_BLOCKED;
                    end
                end
                n.buffer = `DISP_BLANK;
                n.count  = '0;
            end
        end else if (k == 11 || k == 12) begin
            if (n.st == ST_OPEN || k == 12) n.st = ST_LOCKED;
            if (k == 12) n.tries = '0;
            n.buffer = `DISP_BLANK;
            n.count  = '0;
        end
        case (n.st)
            ST_OPEN:    n.display = `DISP_OPEN;
            ST_BLOCKED: n.display = `DISP_BLOCKED;
            default:    n.display = n.buffer;
        endcase
        n.unlocked = (n.st == ST_OPEN);
        return n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, expected);
            $display("Test failures found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // key word for hold cycles, then three idle cycles
    task automatic press(input keys_t word, input int hold);
        @(posedge clk);
        keys  <= word;
        model = lock_model(model, word);
        -> pressed;
        repeat (hold) @(posedge clk);
        keys <= '0;
        repeat (3) @(posedge clk);
    endtask

    // three digits and enter, then the whole beep window
    task automatic enter_code(input code_t code);
        int base;
        press(digit_key(code[11:8]), 1);
        press(digit_key(code[7:4]), 1);
        press(digit_key(code[3:0]), 1);
        base = buzz_high;
        press(enter_key, 1);
        repeat (`BEEP_CYCLES + 8) @(posedge clk);
        check_value("buzzer high cycles", buzz_high - base, model.beep ? `BEEP_CYCLES / 2 : 0);
    endtask

    // outputs settle three cycles after the press edge
    initial begin
        forever begin
            @(pressed);
            repeat (3) @(posedge clk);
            @(negedge clk);
            check_value("display", display, model.display);
            check_value("tries", tries, model.tries);
            check_value("unlocked", unlocked, model.unlocked);
        end
    end

    always @(negedge clk) begin
        if (buzzer) buzz_high <= buzz_high + 1;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("Test failures found");
            $fatal(1, "simulation timed out after %0d cycles", cycle_cnt);
        end
    end

    initial begin
        void'($urandom(32'h70fe_0c15));
        rst  = 1'b1;
        keys = '0;
        model = '{st: ST_LOCKED, buffer: `DISP_BLANK, count: '0, tries: '0,
                  display: `DISP_BLANK, unlocked: 1'b0, beep: 1'b0};
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("display", display, `DISP_BLANK);
        check_value("tries", tries, 0);
        check_value("unlocked", unlocked, 0);
        check_value("buzzer", buzzer, 0);

        // digit entry, junk words and a held key
        press(16'h0002, 1);
        press(16'h0014, 1);             // unused bits
        press(16'h0088, 1);             // two digits at once
        press(digit_key(4'd2), 5);      // held key gives one digit
        press(digit_key(4'd4), 1);
        press(digit_key(4'd6), 1);
        @(negedge clk);
        check_value("display", display, 12'h246);
        press(digit_key(digit_t'($urandom % 10)), 1);   // buffer full
        press(clear_key, 1);

        // correct code, then clear
        enter_code(`LOCK_CODE);
        @(negedge clk);
        check_value("unlocked", unlocked, 1);
        press(clear_key, 1);

        // wrong code, short entry
        enter_code(random_wrong_code());
        press(digit_key(4'd1), 1);
        press(digit_key(4'd9), 1);
        press(enter_key, 1);            // only two digits
        press(clear_key, 1);

        // six wrong codes block the lock
        press(reset_key, 1);
        repeat (`MAX_TRIES) enter_code(random_wrong_code());
        @(negedge clk);
        check_value("display", display, `DISP_BLOCKED);
        check_value("tries", tries, `MAX_TRIES);
        press(digit_key(4'd5), 1);
        press(enter_key, 1);
        press(clear_key, 1);            // empty buffer so the real code goes in
        enter_code(`LOCK_CODE);
        enter_code(random_wrong_code());

        // reset key, reopen, clear during entry
        press(reset_key, 1);
        enter_code(`LOCK_CODE);
        press(clear_key, 1);
        enter_code(random_wrong_code());
        press(digit_key(4'd3), 1);
        press(digit_key(4'd7), 1);
        press(clear_key, 1);
        @(negedge clk);
        check_value("tries", tries, 1);
        check_value("display", display, `DISP_BLANK);

        repeat (2) @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- sim.f
+incdir+rtl
rtl/lock_pkg.sv
rtl/key_decoder.sv
rtl/code_entry.sv
rtl/code_checker.sv
rtl/buzzer_driver.sv
rtl/keypad_lock.sv
testbench/keypad_lock_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the keypad lock testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module keypad_lock_tb \
    -f sim.f \
    -o keypad_lock_sim

./obj_dir/keypad_lock_sim
